/* common/spiSlavePkg.sv */
// Shared definitions for the SPI slave front end
// Word and CSR address widths
// Frame command encoding
// Decoded frame field, CSR bus, burst bus and burst FIFO entry
package spiSlavePkg;

	// ---------------------------------------------------------------------------
	// Widths
	// ---------------------------------------------------------------------------
	localparam int kWordBits    = 32;
	localparam int kUsiAdrsBits = 16;

	// Header bits 31:30
	typedef enum logic [1:0] {
		csrRead  = 2'b00,
		csrWrite = 2'b01,
		reserved = 2'b10,
		ufiWrite = 2'b11
	} spiCmdE;

	// One decoded word with its frame context
	typedef struct packed {
		logic [kWordBits-1:0] data;
		logic [kWordBits-1:0] adrs;
		spiCmdE               cmd;
		// Words left, this one included
		logic [15:0]          dLen;
		logic                 vd;
	} spiFieldS;

	// CSR write side
	typedef struct packed {
		logic [kWordBits-1:0]    wd;
		logic [kUsiAdrsBits-1:0] adrs;
		logic                    we;
	} usiBusS;

	// Burst write side
	typedef struct packed {
		logic [kWordBits-1:0] wd;
		logic [kWordBits-1:0] adrs;
		logic                 we;
		// High during the transfer period
		logic                 wvd;
	} ufiBusS;

	// Burst FIFO entry
	typedef struct packed {
		logic [kWordBits-1:0] adrs;
		logic [kWordBits-1:0] data;
	} ufiWriteS;

endpackage

/* spiSlave/spiSlaveSerdes.sv */
// SPI mode 0 serializer
// Two-flop sync of SCLK, CS and MOSI, edge detect on SCLK
// MSB-first receive shift with one-cycle word pulse
// MSB-first transmit shift, reloaded at every word start
`timescale 1ns/1ps

module spiSlaveSerdes
(
	input  logic                               iSysClk,
	input  logic                               arstN,
	input  logic                               spiSclk,
	input  logic                               spiCs,
	input  logic                               spiMosi,
	input  logic [spiSlavePkg::kWordBits-1:0]  txWord,
	output logic                               spiMiso,
	output logic [spiSlavePkg::kWordBits-1:0]  rxWord,
	output logic                               rxDone,
	output logic                               csActive
);

	localparam int kCntBits = $clog2(spiSlavePkg::kWordBits);

	// ---------------------------------------------------------------------------
	// Pin synchronizers
	// ---------------------------------------------------------------------------
	// Bit 2 of the SCLK pipe is the previous synced level
	logic [2:0] sclkPipe;
	logic [1:0] csPipe;
	logic [1:0] mosiPipe;
	logic       sclkRise;
	logic       sclkFall;

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sclkPipe <= '0;
			// CS idles high
			csPipe   <= '1;
			mosiPipe <= '0;
		end
		else
		begin
			sclkPipe <= {sclkPipe[1:0], spiSclk};
			csPipe   <= {csPipe[0], spiCs};
			mosiPipe <= {mosiPipe[0], spiMosi};
		end
	end

	assign sclkRise = sclkPipe[1] & ~sclkPipe[2];
	assign sclkFall = ~sclkPipe[1] & sclkPipe[2];
	// CS is active low
	assign csActive = ~csPipe[1];

	// ---------------------------------------------------------------------------
	// Bit counter and word pulse
	// ---------------------------------------------------------------------------
	logic [kCntBits-1:0]                bitCnt;
	logic [spiSlavePkg::kWordBits-1:0] rxShift;
	logic [spiSlavePkg::kWordBits-1:0] txShift;

	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			bitCnt <= '0;
			rxDone <= 1'b0;
		end
		else
		begin
			rxDone <= 1'b0;
			// CS high restarts word alignment
			if (!csActive)
				bitCnt <= '0;
			else if (sclkRise)
			begin
				// Counter wraps to zero after bit 0
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == kCntBits'(spiSlavePkg::kWordBits - 1))
					rxDone <= 1'b1;
			end
		end
	end

	// Receive shift, MSB first on rising SCLK
	always_ff @(posedge iSysClk)
	begin
		if (csActive && sclkRise)
		begin
			rxShift <= {rxShift[spiSlavePkg::kWordBits-2:0], mosiPipe[1]};
			if (bitCnt == kCntBits'(spiSlavePkg::kWordBits - 1))
				rxWord <= {rxShift[spiSlavePkg::kWordBits-2:0], mosiPipe[1]};
		end
	end

	// Transmit shift
	// Follows txWord until the first rising edge of a word
	// Then advances on each falling edge
	always_ff @(posedge iSysClk)
	begin
		if (!csActive || bitCnt == '0)
			txShift <= txWord;
		else if (sclkFall)
			txShift <= {txShift[spiSlavePkg::kWordBits-2:0], 1'b0};
	end

	assign spiMiso = txShift[spiSlavePkg::kWordBits-1];

endmodule

/* spiSlave/spiSlaveCtrl.sv */
// Frame sequencer for the SPI slave
// Parses header, address and data words of a frame
// Tracks word address and remaining length
// Drives the decoded field and the MISO word for CSR reads
`timescale 1ns/1ps

module spiSlaveCtrl
(
	input  logic                               iSysClk,
	input  logic                               arstN,
	input  logic [spiSlavePkg::kWordBits-1:0]  rxWord,
	input  logic                               rxDone,
	input  logic                               csActive,
	input  logic [spiSlavePkg::kWordBits-1:0]  misoWord,
	output logic [spiSlavePkg::kWordBits-1:0]  txWord,
	output spiSlavePkg::spiFieldS              field
);

	// Idle holds after a finished frame until CS goes high
	typedef enum logic [1:0] {
		sIdle,
		sHeader,
		sAdrs,
		sData
	} stateE;

	stateE                             state;
	logic [15:0]                       remLen;
	logic                              fieldVd;
	spiSlavePkg::spiCmdE               fieldCmd;
	logic [15:0]                       fieldLen;
	logic [spiSlavePkg::kWordBits-1:0] fieldAdrs;
	logic [spiSlavePkg::kWordBits-1:0] fieldData;

	// ---------------------------------------------------------------------------
	// Sequencer
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= sIdle;
			remLen    <= '0;
			fieldVd   <= 1'b0;
			fieldCmd  <= spiSlavePkg::csrRead;
			fieldLen  <= '0;
			fieldAdrs <= '0;
		end
		else
		begin
			fieldVd <= 1'b0;
			if (!csActive)
			begin
				// Between frames, also drops an aborted frame
				state    <= sHeader;
				fieldLen <= '0;
			end
			else
			begin
				case (state)
					sIdle:
						state <= sIdle;
					sHeader:
						if (rxDone)
						begin
							fieldCmd <= spiSlavePkg::spiCmdE'(rxWord[31:30]);
							fieldLen <= rxWord[15:0];
							remLen   <= rxWord[15:0];
							state    <= sAdrs;
						end
					sAdrs:
						if (rxDone)
						begin
							// Also the read address for the first data word
							fieldAdrs <= rxWord;
							state     <= (remLen == '0) ? sIdle : sData;
						end
					sData:
						if (rxDone)
						begin
							fieldVd  <= 1'b1;
							fieldLen <= remLen;
							remLen   <= remLen - 1'b1;
							if (remLen == 16'd1)
								state <= sIdle;
						end
					default:
						state <= sIdle;
				endcase
				// Step to the next word address after each data word
				if (fieldVd)
				begin
					fieldAdrs <= fieldAdrs + 1'b1;
					fieldLen  <= remLen;
				end
			end
		end
	end

	// Data word payload
	always_ff @(posedge iSysClk)
	begin
		if (rxDone && state == sData)
			fieldData <= rxWord;
	end

	assign field = '{
		data: fieldData,
		adrs: fieldAdrs,
		cmd:  fieldCmd,
		dLen: fieldLen,
		vd:   fieldVd
	};

	// Read data only inside the data phase of a CSR read
	assign txWord = (state == sData && fieldCmd == spiSlavePkg::csrRead) ? misoWord : '0;

endmodule

/* source/spiSignalMux.sv */
// Field to bus mux for the SPI slave
// One-cycle register stage onto the CSR and burst buses
// Write enables decoded from valid flag and command
// CSR read data passed straight back as the MISO word
`timescale 1ns/1ps

module spiSignalMux
(
	input  logic                               iSysClk,
	input  logic                               arstN,
	input  spiSlavePkg::spiFieldS              field,
	input  logic [spiSlavePkg::kWordBits-1:0]  csrRd,
	output spiSlavePkg::usiBusS                usiBus,
	output spiSlavePkg::ufiBusS                ufiBus,
	output logic [spiSlavePkg::kWordBits-1:0]  misoWord
);

	logic [spiSlavePkg::kWordBits-1:0] wdQ;
	logic [spiSlavePkg::kWordBits-1:0] adrsQ;
	logic                              usiWe;
	logic                              ufiWe;
	logic                              ufiWvd;

	// ---------------------------------------------------------------------------
	// Data and address, shared by both buses
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		wdQ   <= field.data;
		adrsQ <= field.adrs;
	end

	// ---------------------------------------------------------------------------
	// Enables, delayed to line up with the data
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			usiWe  <= 1'b0;
			ufiWe  <= 1'b0;
			ufiWvd <= 1'b0;
		end
		else
		begin
			usiWe  <= field.vd && (field.cmd == spiSlavePkg::csrWrite);
			ufiWe  <= field.vd && (field.cmd == spiSlavePkg::ufiWrite);
			// Transfer period lasts while words remain
			ufiWvd <= (field.dLen != '0);
		end
	end

	assign usiBus   = '{wd: wdQ, adrs: adrsQ[spiSlavePkg::kUsiAdrsBits-1:0], we: usiWe};
	assign ufiBus   = '{wd: wdQ, adrs: adrsQ, we: ufiWe, wvd: ufiWvd};
	// No register on the read path
	assign misoWord = csrRd;

endmodule

/* source/csrRegFile.sv */
// Control and status register file
// Written from the CSR bus
// Combinational read port addressed by the frame sequencer
// Low address bits only, so addresses wrap
`timescale 1ns/1ps

module csrRegFile #(
	parameter int pCsrAdrsBit = 4
)
(
	input  logic                                  iSysClk,
	input  logic                                  arstN,
	input  spiSlavePkg::usiBusS                   usiBus,
	input  logic [spiSlavePkg::kUsiAdrsBits-1:0]  rdAdrs,
	output logic [spiSlavePkg::kWordBits-1:0]     csrRd
);

	localparam int kRegNum = 2 ** pCsrAdrsBit;

	logic [spiSlavePkg::kWordBits-1:0] regs [kRegNum];
	logic [pCsrAdrsBit-1:0]            wrIdx;
	logic [pCsrAdrsBit-1:0]            rdIdx;

	// Upper address bits dropped
	assign wrIdx = usiBus.adrs[pCsrAdrsBit-1:0];
	assign rdIdx = rdAdrs[pCsrAdrsBit-1:0];

	// ---------------------------------------------------------------------------
	// Write port
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			// All registers read zero after reset
			for (int i = 0; i < kRegNum; i++)
				regs[i] <= '0;
		end
		else if (usiBus.we)
		begin
			regs[wrIdx] <= usiBus.wd;
		end
	end

	// ---------------------------------------------------------------------------
	// Read port
	// ---------------------------------------------------------------------------
	assign csrRd = regs[rdIdx];

endmodule

/* source/ufiWriteBridge.sv */
// Burst write bridge
// Circular FIFO of address and data entries
// Four-phase req/ack master draining the FIFO to memory
// Sticky overflow flag on a write into a full FIFO
`timescale 1ns/1ps

module ufiWriteBridge #(
	parameter int pFifoDepth = 8
)
(
	input  logic                               iSysClk,
	input  logic                               arstN,
	input  spiSlavePkg::ufiBusS                ufiBus,
	input  logic                               memAck,
	output logic                               memReq,
	output logic [spiSlavePkg::kWordBits-1:0]  memAdrs,
	output logic [spiSlavePkg::kWordBits-1:0]  memData,
	output logic                               ufiOverflow
);

	localparam int kPtrBits = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
	localparam int kCntBits = $clog2(pFifoDepth + 1);

	// Req high, ack pending; then req low, ack release pending
	typedef enum logic [1:0] {
		sIdle,
		sReq,
		sRelease
	} stateE;

	spiSlavePkg::ufiWriteS fifo [pFifoDepth];
	logic [kPtrBits-1:0]   wrPtr;
	logic [kPtrBits-1:0]   rdPtr;
	logic [kCntBits-1:0]   count;
	logic                  full;
	logic                  push;
	logic                  pop;
	stateE                 state;

	assign full = (count == kCntBits'(pFifoDepth));
	// Writes into a full FIFO are lost
	assign push = ufiBus.we && !full;
	assign pop  = (state == sIdle) && (count != '0);

	// ---------------------------------------------------------------------------
	// FIFO storage
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (push)
			fifo[wrPtr] <= '{adrs: ufiBus.adrs, data: ufiBus.wd};
		// Hold the memory port stable for the whole handshake
		if (pop)
		begin
			memAdrs <= fifo[rdPtr].adrs;
			memData <= fifo[rdPtr].data;
		end
	end

	// ---------------------------------------------------------------------------
	// Pointers, fill level, handshake
	// ---------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			state       <= sIdle;
			memReq      <= 1'b0;
			ufiOverflow <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == kPtrBits'(pFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == kPtrBits'(pFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + kCntBits'(push) - kCntBits'(pop);
			if (ufiBus.we && full)
				ufiOverflow <= 1'b1;

			case (state)
				sIdle:
					if (pop)
					begin
						memReq <= 1'b1;
						state  <= sReq;
					end
				sReq:
					if (memAck)
					begin
						memReq <= 1'b0;
						state  <= sRelease;
					end
				sRelease:
					// Next entry only after ack falls
					if (!memAck)
						state <= sIdle;
				default:
					state <= sIdle;
			endcase
		end
	end

endmodule

/* source/spiSlaveTop.sv */
// SPI slave front end, top level
// Serializer, frame sequencer, bus mux, CSR register file
// and burst write bridge wired together
`timescale 1ns/1ps

module spiSlaveTop #(
	parameter int pCsrAdrsBit = 4,
	parameter int pFifoDepth  = 8
)
(
	input  logic                               iSysClk,
	input  logic                               arstN,
	// SPI pins
	input  logic                               spiSclk,
	input  logic                               spiCs,
	input  logic                               spiMosi,
	output logic                               spiMiso,
	// Memory port
	output logic                               memReq,
	input  logic                               memAck,
	output logic [spiSlavePkg::kWordBits-1:0]  memAdrs,
	output logic [spiSlavePkg::kWordBits-1:0]  memData,
	output logic                               ufiOverflow
);

	logic [spiSlavePkg::kWordBits-1:0] rxWord;
	logic                              rxDone;
	logic                              csActive;
	logic [spiSlavePkg::kWordBits-1:0] txWord;
	logic [spiSlavePkg::kWordBits-1:0] misoWord;
	logic [spiSlavePkg::kWordBits-1:0] csrRd;
	spiSlavePkg::spiFieldS             field;
	spiSlavePkg::usiBusS               usiBus;
	spiSlavePkg::ufiBusS               ufiBus;

	spiSlaveSerdes i_spiSlaveSerdes (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.spiSclk  (spiSclk),
		.spiCs    (spiCs),
		.spiMosi  (spiMosi),
		.txWord   (txWord),
		.spiMiso  (spiMiso),
		.rxWord   (rxWord),
		.rxDone   (rxDone),
		.csActive (csActive)
	);

	spiSlaveCtrl i_spiSlaveCtrl (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.rxWord   (rxWord),
		.rxDone   (rxDone),
		.csActive (csActive),
		.misoWord (misoWord),
		.txWord   (txWord),
		.field    (field)
	);

	spiSignalMux i_spiSignalMux (
		.iSysClk  (iSysClk),
		.arstN    (arstN),
		.field    (field),
		.csrRd    (csrRd),
		.usiBus   (usiBus),
		.ufiBus   (ufiBus),
		.misoWord (misoWord)
	);

	// Read address follows the sequencer's current word address
	csrRegFile #(
		.pCsrAdrsBit (pCsrAdrsBit)
	) i_csrRegFile (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.usiBus  (usiBus),
		.rdAdrs  (field.adrs[spiSlavePkg::kUsiAdrsBits-1:0]),
		.csrRd   (csrRd)
	);

	ufiWriteBridge #(
		.pFifoDepth (pFifoDepth)
	) i_ufiWriteBridge (
		.iSysClk     (iSysClk),
		.arstN       (arstN),
		.ufiBus      (ufiBus),
		.memAck      (memAck),
		.memReq      (memReq),
		.memAdrs     (memAdrs),
		.memData     (memData),
		.ufiOverflow (ufiOverflow)
	);

endmodule

/* verif/tbClkGen.sv */
// Testbench clock and reset source
// 8 ns system clock
// Active-low reset held for the first 3 cycles
`timescale 1ns/1ps

module tbClkGen
(
	output logic iSysClk,
	output logic arstN
);

	// 4 ns half period
	initial
	begin
		iSysClk = 1'b0;
		forever
			#4 iSysClk = ~iSysClk;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (3) @(posedge iSysClk);
		arstN <= 1'b1;
	end

endmodule

/* verif/spiSlaveChecker.sv */
// Testbench checker for the SPI slave
// SPI sniffer decoding MOSI frames and sampling MISO
// Register model for CSR writes and read-back
// Expected burst queue compared against the memory port
// Four-phase handshake and overflow watch
`timescale 1ns/1ps

module spiSlaveChecker #(
	parameter int pCsrAdrsBit = 4
)
(
	input  logic        iSysClk,
	input  logic        arstN,
	input  logic        spiSclk,
	input  logic        spiCs,
	input  logic        spiMosi,
	input  logic        spiMiso,
	input  logic        memReq,
	input  logic        memAck,
	input  logic [31:0] memAdrs,
	input  logic [31:0] memData,
	input  logic        ufiOverflow,
	output int          checks,
	output int          dataErrs,
	output int          protoErrs,
	output int          burstPending
);

	localparam int kRegNum = 2 ** pCsrAdrsBit;

	logic [31:0] regModel [kRegNum];
	// Entries are {address, data}
	logic [63:0] expQ [$];
	logic [63:0] expEntry;
	logic        prevSclk;
	logic        prevReq;
	logic        overflowSeen;
	int          bitIdx;
	int          wordIdx;
	logic [31:0] mosiSh;
	logic [31:0] misoSh;
	logic [1:0]  cmd;
	logic [31:0] frameAdrs;
	logic [15:0] frameLen;
	logic [31:0] reqAdrs;
	logic [31:0] reqData;

	// One complete word of the current frame
	task automatic decodeWord(input logic [31:0] mosiW, input logic [31:0] misoW);
		logic [31:0]            wordAdrs;
		logic [pCsrAdrsBit-1:0] idx;
		wordAdrs = frameAdrs + (wordIdx - 2);
		idx      = wordAdrs[pCsrAdrsBit-1:0];
		if (wordIdx == 0)
		begin
			cmd      = mosiW[31:30];
			frameLen = mosiW[15:0];
		end
		else if (wordIdx == 1)
			frameAdrs = mosiW;
		else if (wordIdx - 2 < frameLen)
		begin
			case (cmd)
				2'b00:
				begin
					checks++;
					if (misoW !== regModel[idx])
					begin
						$display("[ERROR] %0t: CSR read at %h returned %h, expected %h",
							$time, wordAdrs, misoW, regModel[idx]);
						dataErrs++;
					end
				end
				2'b01:
					regModel[idx] = mosiW;
				2'b11:
					expQ.push_back({wordAdrs, mosiW});
				// Reserved frames leave no trace
				default:
					;
			endcase
		end
	endtask

	// ---------------------------------------------------------------------------
	// Pin sniffer and memory port monitor
	// ---------------------------------------------------------------------------
	always @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < kRegNum; i++)
				regModel[i] = '0;
			expQ.delete();
			bitIdx       = 0;
			wordIdx      = 0;
			prevSclk     = 1'b0;
			prevReq      = 1'b0;
			overflowSeen = 1'b0;
			checks       = 0;
			dataErrs     = 0;
			protoErrs    = 0;
			burstPending <= 0;
		end
		else
		begin
			// CS high restarts the frame
			if (spiCs)
			begin
				bitIdx  = 0;
				wordIdx = 0;
			end
			else if (spiSclk && !prevSclk)
			begin
				mosiSh = {mosiSh[30:0], spiMosi};
				misoSh = {misoSh[30:0], spiMiso};
				bitIdx++;
				if (bitIdx == 32)
				begin
					decodeWord(mosiSh, misoSh);
					bitIdx = 0;
					wordIdx++;
				end
			end
			prevSclk = spiSclk;

			// Rising request needs the previous ack gone
			if (memReq && !prevReq)
			begin
				if (memAck)
				begin
					$display("[ERROR] %0t: memReq rose while memAck still high", $time);
					protoErrs++;
				end
				if (expQ.size() == 0)
				begin
					$display("[ERROR] %0t: unexpected memory write %h to %h",
						$time, memData, memAdrs);
					dataErrs++;
				end
				else
				begin
					expEntry = expQ.pop_front();
					checks++;
					if ({memAdrs, memData} !== expEntry)
					begin
						$display("[ERROR] %0t: memory write %h to %h, expected %h to %h",
							$time, memData, memAdrs, expEntry[31:0], expEntry[63:32]);
						dataErrs++;
					end
				end
				reqAdrs = memAdrs;
				reqData = memData;
			end
			else if (memReq && (memAdrs !== reqAdrs || memData !== reqData))
			begin
				$display("[ERROR] %0t: memory port changed during request", $time);
				protoErrs++;
			end
			if (!memReq && prevReq && !memAck)
			begin
				$display("[ERROR] %0t: memReq dropped before memAck rose", $time);
				protoErrs++;
			end
			prevReq = memReq;

			// Overflow flag must stay low
			if (ufiOverflow !== 1'b0 && !overflowSeen)
			begin
				$display("[ERROR] %0t: ufiOverflow is %b, expected 0", $time, ufiOverflow);
				protoErrs++;
				overflowSeen = 1'b1;
			end
			burstPending <= expQ.size();
		end
	end

endmodule

/* verif/spiSlaveTb.sv */
// Testbench top for the SPI slave front end
// SPI mode 0 master driver with framed random traffic
// Memory ack responder with random delay
// Clock source, DUT and checker instances, final report
`timescale 1ns/1ps

module spiSlaveTb;

	localparam int kCsrAdrsBit   = 4;
	localparam int kFifoDepth    = 8;
	localparam int kRandFrames   = 40;
	localparam int kWordGap      = 4;
	localparam int kFrameGap     = 8;
	localparam int kResetTimeout = 20;
	localparam int kDrainTimeout = 2000;

	logic                              iSysClk;
	logic                              arstN;
	logic                              spiSclk = 1'b0;
	logic                              spiCs   = 1'b1;
	logic                              spiMosi = 1'b0;
	logic                              spiMiso;
	logic                              memReq;
	logic                              memAck  = 1'b0;
	logic [spiSlavePkg::kWordBits-1:0] memAdrs;
	logic [spiSlavePkg::kWordBits-1:0] memData;
	logic                              ufiOverflow;
	integer                            seed    = 32'h7c8b_9a59;
	integer                            ackSeed = 32'h7c8b_9a59;
	logic                              ackArmed;
	int                                ackWait;
	int                                checkCnt;
	int                                dataErrs;
	int                                protoErrs;
	int                                burstPending;
	int                                timeouts;
	logic                              aborted;

	tbClkGen i_tbClkGen (
		.iSysClk (iSysClk),
		.arstN   (arstN)
	);

	spiSlaveTop #(
		.pCsrAdrsBit (kCsrAdrsBit),
		.pFifoDepth  (kFifoDepth)
	) i_spiSlaveTop (
		.iSysClk     (iSysClk),
		.arstN       (arstN),
		.spiSclk     (spiSclk),
		.spiCs       (spiCs),
		.spiMosi     (spiMosi),
		.spiMiso     (spiMiso),
		.memReq      (memReq),
		.memAck      (memAck),
		.memAdrs     (memAdrs),
		.memData     (memData),
		.ufiOverflow (ufiOverflow)
	);

	spiSlaveChecker #(
		.pCsrAdrsBit (kCsrAdrsBit)
	) i_spiSlaveChecker (
		.iSysClk      (iSysClk),
		.arstN        (arstN),
		.spiSclk      (spiSclk),
		.spiCs        (spiCs),
		.spiMosi      (spiMosi),
		.spiMiso      (spiMiso),
		.memReq       (memReq),
		.memAck       (memAck),
		.memAdrs      (memAdrs),
		.memData      (memData),
		.ufiOverflow  (ufiOverflow),
		.checks       (checkCnt),
		.dataErrs     (dataErrs),
		.protoErrs    (protoErrs),
		.burstPending (burstPending)
	);

	// ---------------------------------------------------------------------------
	// Memory responder, ack after 0 to 7 cycles
	// ---------------------------------------------------------------------------
	always @(posedge iSysClk)
	begin
		if (!arstN)
		begin
			memAck   <= 1'b0;
			ackArmed <= 1'b0;
		end
		else if (memReq && !memAck)
		begin
			if (!ackArmed)
			begin
				ackArmed <= 1'b1;
				ackWait  <= {$random(ackSeed)} % 8;
			end
			else if (ackWait == 0)
			begin
				memAck   <= 1'b1;
				ackArmed <= 1'b0;
			end
			else
				ackWait <= ackWait - 1;
		end
		// Release once the request is gone
		else if (!memReq && memAck)
			memAck <= 1'b0;
	end

	// ---------------------------------------------------------------------------
	// SPI master
	// ---------------------------------------------------------------------------
	// MSB first, 4-clock half period, MOSI changes with SCLK low
	task automatic sendWord(input logic [31:0] word);
		for (int b = 31; b >= 0; b--)
		begin
			@(posedge iSysClk);
			spiSclk <= 1'b0;
			spiMosi <= word[b];
			repeat (3) @(posedge iSysClk);
			@(posedge iSysClk);
			spiSclk <= 1'b1;
			repeat (3) @(posedge iSysClk);
		end
		@(posedge iSysClk);
		spiSclk <= 1'b0;
		repeat (kWordGap) @(posedge iSysClk);
	endtask

	// Header, address, then len random data words
	task automatic runFrame(input logic [1:0] cmd, input logic [31:0] adrs,
		input logic [15:0] len);
		logic [31:0] header;
		logic [31:0] data;
		header        = $random(seed);
		header[31:30] = cmd;
		header[15:0]  = len;
		@(posedge iSysClk);
		spiCs <= 1'b0;
		repeat (kWordGap) @(posedge iSysClk);
		sendWord(header);
		sendWord(adrs);
		for (int k = 0; k < len; k++)
		begin
			data = $random(seed);
			sendWord(data);
		end
		@(posedge iSysClk);
		spiCs <= 1'b1;
		repeat (kFrameGap) @(posedge iSysClk);
	endtask

	task automatic waitReset();
		int n;
		n = 0;
		while (arstN !== 1'b1 && n < kResetTimeout)
		begin
			@(posedge iSysClk);
			n++;
		end
		if (arstN !== 1'b1)
		begin
			$display("Timeout: reset was not released within %0d cycles", kResetTimeout);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	// All expected burst writes seen and the handshake idle
	task automatic waitDrain();
		int n;
		n = 0;
		while ((burstPending != 0 || memReq || memAck) && n < kDrainTimeout)
		begin
			@(posedge iSysClk);
			n++;
		end
		if (burstPending != 0 || memReq || memAck)
		begin
			$display("Timeout: memory port still busy after %0d cycles, %0d writes missing",
				kDrainTimeout, burstPending);
			timeouts++;
		end
	endtask

	// ---------------------------------------------------------------------------
	// Stimulus sequence
	// ---------------------------------------------------------------------------
	initial
	begin
		logic [1:0]  cmd;
		logic [31:0] adrs;
		logic [15:0] len;
		timeouts = 0;
		aborted  = 1'b0;
		waitReset();
		if (!aborted)
		begin
			// Registers after reset
			runFrame(2'b00, 32'h0000_0000, 16'd16);
			// Full write with address wrap
			runFrame(2'b01, 32'h1234_5678, 16'd16);
			// Frames that must change nothing
			runFrame(2'b10, 32'h0000_0005, 16'd3);
			runFrame(2'b01, 32'h0000_0002, 16'd0);
			runFrame(2'b11, 32'h0000_0040, 16'd0);
			// Burst across the 32-bit address boundary
			runFrame(2'b11, 32'hffff_fffe, 16'd6);
			runFrame(2'b00, 32'h0000_0008, 16'd16);
			for (int i = 0; i < kRandFrames; i++)
			begin
				cmd  = $random(seed);
				adrs = $random(seed);
				len  = {$random(seed)} % 7;
				runFrame(cmd, adrs, len);
			end
			runFrame(2'b00, 32'h0000_0000, 16'd16);
			waitDrain();
		end
		$display("Summary: %0d checks, %0d data errors, %0d protocol errors, %0d timeouts",
			checkCnt, dataErrs, protoErrs, timeouts);
		if (dataErrs + protoErrs + timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
common/spiSlavePkg.sv
spiSlave/spiSlaveSerdes.sv
spiSlave/spiSlaveCtrl.sv
source/spiSignalMux.sv
source/csrRegFile.sv
source/ufiWriteBridge.sv
source/spiSlaveTop.sv
verif/tbClkGen.sv
verif/spiSlaveChecker.sv
verif/spiSlaveTb.sv
